//--- branch_pkg.sv
// Branch resolution unit shared definitions
// Instruction field types, RISC-V opcode and funct3 codes, the control-flow
// kind of a slot and the structs passed between decode, execute and result

package branch_pkg;

  ////////////////////
  // Field types

  typedef logic [31:0] insn_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  // Upper bit means predicted taken
  typedef logic [1:0]  bp_predict_t;

  ////////////////////
  // Major opcodes

  localparam opcode_t OPC_JAL     = 7'b1101111;
  localparam opcode_t OPC_JALR    = 7'b1100111;
  localparam opcode_t OPC_BRANCH  = 7'b1100011;
  localparam opcode_t OPC_MISCMEM = 7'b0001111;

  ////////////////////
  // Minor function codes

  localparam funct3_t F3_BEQ     = 3'b000;
  localparam funct3_t F3_BNE     = 3'b001;
  localparam funct3_t F3_BLT     = 3'b100;
  localparam funct3_t F3_BGE     = 3'b101;
  localparam funct3_t F3_BLTU    = 3'b110;
  localparam funct3_t F3_BGEU    = 3'b111;
  localparam funct3_t F3_JALR    = 3'b000;
  localparam funct3_t F3_FENCE   = 3'b000;
  localparam funct3_t F3_FENCE_I = 3'b001;

  // Control-flow kind of the slot
  typedef enum logic [2:0] {
    BR_NONE    = 3'd0,
    BR_JAL     = 3'd1,
    BR_JALR    = 3'd2,
    BR_BRANCH  = 3'd3,
    BR_FENCE   = 3'd4,
    BR_FENCE_I = 3'd5
  } br_kind_e;

  // Decode to execute
  typedef struct packed {
    br_kind_e    kind;
    funct3_t     funct3;
    logic [31:0] imm;
    logic        is_16bit;
  } br_decode_t;

  // Execute to result
  typedef struct packed {
    logic bubble;
    logic taken;
    logic bp_update;
    logic flush;
    logic ic_invalidate;
    logic dc_clean;
    logic misaligned;
  } br_ctrl_t;

endpackage

//--- branch_decode.sv
// Branch decode
// Classifies the instruction word as JAL, JALR, conditional branch, FENCE,
// FENCE.I or none, and extracts the sign-extended J and B immediates

`timescale 1ns/1ns

module branch_decode (
  input  branch_pkg::insn_t      insn_i,
  input  logic                   bubble_i,
  output branch_pkg::br_decode_t dec_o
);
  import branch_pkg::*;

  opcode_t     opcode;
  funct3_t     funct3;
  logic        fence_regs_zero;
  logic [20:0] imm_j;
  logic [12:0] imm_b;
  br_kind_e    kind;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];

  // FENCE and FENCE.I require rs1 and rd to be x0
  assign fence_regs_zero = (insn_i[19:15] == 5'd0) && (insn_i[11:7] == 5'd0);

  ////////////////////
  // Immediates

  assign imm_j = {insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
  assign imm_b = {insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};

  ////////////////////
  // Kind

  always_comb begin
    kind = BR_NONE;
    if (!bubble_i) begin
      case (opcode)
        OPC_JAL: begin
          kind = BR_JAL;
        end
        OPC_JALR: begin
          if (funct3 == F3_JALR) begin
            kind = BR_JALR;
          end
        end
        OPC_BRANCH: begin
          case (funct3)
            F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: kind = BR_BRANCH;
            default: kind = BR_NONE;
          endcase
        end
        OPC_MISCMEM: begin
          if (fence_regs_zero && funct3 == F3_FENCE) begin
            kind = BR_FENCE;
          end else if (fence_regs_zero && funct3 == F3_FENCE_I &&
                       insn_i[31:20] == 12'd0) begin
            kind = BR_FENCE_I;
          end
        end
        default: begin
          kind = BR_NONE;
        end
      endcase
    end
  end

  always_comb begin
    dec_o.kind   = kind;
    dec_o.funct3 = funct3;
    // JAL uses the J-type immediate, everything else the B-type one
    if (kind == BR_JAL) begin
      dec_o.imm = 32'($signed(imm_j));
    end else begin
      dec_o.imm = 32'($signed(imm_b));
    end
    dec_o.is_16bit = ~&insn_i[1:0];
  end

endmodule

//--- branch_execute.sv
// Branch execute
// Evaluates the branch condition, computes jump and branch targets and the
// fall-through PC, and forms the flush, predictor and cache requests.
// Also flags misaligned targets for the selected alignment

`timescale 1ns/1ns

module branch_execute #(
  parameter int XLEN    = 32,
  parameter int HAS_RVC = 0
) (
  input  branch_pkg::br_decode_t  dec_i,
  input  logic [XLEN-1:0]         pc_i,
  input  logic [XLEN-1:0]         opa_i,
  input  logic [XLEN-1:0]         opb_i,
  input  branch_pkg::bp_predict_t bp_predict_i,
  input  logic                    misaligned_i,
  output branch_pkg::br_ctrl_t    ctrl_o,
  output logic [XLEN-1:0]         nxt_pc_o
);
  import branch_pkg::*;

  // Low PC bits that must be zero for a legal target
  localparam logic [1:0] ALIGN_MASK = (HAS_RVC != 0) ? 2'b01 : 2'b11;

  logic [XLEN-1:0] imm_ext;
  logic [XLEN-1:0] pc_seq;
  logic [XLEN-1:0] pc_rel;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] jalr_tgt;
  logic            op_eq;
  logic            op_lt;
  logic            op_ltu;
  logic            cond;
  logic            pred_taken;

  ////////////////////
  // Addresses

  assign imm_ext  = XLEN'($signed(dec_i.imm));
  assign pc_seq   = pc_i + (dec_i.is_16bit ? XLEN'(2) : XLEN'(4));
  assign pc_rel   = pc_i + imm_ext;
  assign jalr_sum = opa_i + opb_i;
  assign jalr_tgt = {jalr_sum[XLEN-1:1], 1'b0};

  assign pred_taken = bp_predict_i[1];

  ////////////////////
  // Branch condition

  assign op_eq  = (opa_i == opb_i);
  assign op_lt  = ($signed(opa_i) < $signed(opb_i));
  assign op_ltu = (opa_i < opb_i);

  always_comb begin
    case (dec_i.funct3)
      F3_BEQ:  cond = op_eq;
      F3_BNE:  cond = ~op_eq;
      F3_BLT:  cond = op_lt;
      F3_BGE:  cond = ~op_lt;
      F3_BLTU: cond = op_ltu;
      F3_BGEU: cond = ~op_ltu;
      default: cond = 1'b0;
    endcase
  end

  ////////////////////
  // Control and next PC

  always_comb begin
    logic changes_flow;
    logic target_bad;

    ctrl_o       = '0;
    nxt_pc_o     = pc_seq;
    changes_flow = 1'b0;

    case (dec_i.kind)
      BR_JAL: begin
        changes_flow = 1'b1;
        ctrl_o.taken = 1'b1;
        // Fetch already redirected when the jump was predicted
        ctrl_o.flush = ~pred_taken;
        nxt_pc_o     = pc_rel;
      end
      BR_JALR: begin
        changes_flow = 1'b1;
        ctrl_o.taken = 1'b1;
        ctrl_o.flush = 1'b1;
        nxt_pc_o     = jalr_tgt;
      end
      BR_BRANCH: begin
        changes_flow     = 1'b1;
        ctrl_o.taken     = cond;
        ctrl_o.bp_update = 1'b1;
        ctrl_o.flush     = cond ^ pred_taken;
        nxt_pc_o         = cond ? pc_rel : pc_seq;
      end
      BR_FENCE_I: begin
        ctrl_o.flush         = 1'b1;
        ctrl_o.ic_invalidate = 1'b1;
        ctrl_o.dc_clean      = 1'b1;
      end
      BR_FENCE: begin
        // Treated as a no-op that retires
        ctrl_o.bubble = 1'b0;
      end
      default: begin
        ctrl_o.bubble = 1'b1;
      end
    endcase

    target_bad        = |(nxt_pc_o[1:0] & ALIGN_MASK);
    ctrl_o.misaligned = misaligned_i | (changes_flow & target_bad);
  end

endmodule

//--- branch_result.sv
// Branch result registers
// Registers the resolved control-flow result with stall and kill handling,
// and keeps the global history of resolved branch outcomes

`timescale 1ns/1ns

module branch_result #(
  parameter int              XLEN           = 32,
  parameter logic [XLEN-1:0] PC_INIT        = 'h200,
  parameter int              BP_GLOBAL_BITS = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      stall_i,
  input  logic                      kill_i,
  input  branch_pkg::br_ctrl_t      ctrl_i,
  input  logic [XLEN-1:0]           nxt_pc_i,
  input  branch_pkg::bp_predict_t   bp_predict_i,
  input  logic [BP_GLOBAL_BITS-1:0] bp_history_i,
  output logic [XLEN-1:0]           nxt_pc_o,
  output logic                      bubble_o,
  output logic                      flush_o,
  output logic                      ic_invalidate_o,
  output logic                      dc_clean_o,
  output logic                      misaligned_o,
  output branch_pkg::bp_predict_t   bp_predict_o,
  output logic                      bp_btaken_o,
  output logic                      bp_update_o,
  output logic [BP_GLOBAL_BITS-1:0] bp_history_update_o,
  output logic [BP_GLOBAL_BITS-1:0] bp_history_o
);

  logic                    pulse_en;
  logic [BP_GLOBAL_BITS:0] history;

  // Pulses only leave for a slot that advances and is not killed
  assign pulse_en = ~stall_i & ~kill_i;

  ////////////////////
  // Slot state

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nxt_pc_o            <= PC_INIT;
      bubble_o            <= 1'b1;
      misaligned_o        <= 1'b0;
      bp_predict_o        <= '0;
      bp_btaken_o         <= 1'b0;
      bp_history_update_o <= '0;
    end else if (!stall_i) begin
      nxt_pc_o            <= nxt_pc_i;
      bubble_o            <= kill_i | ctrl_i.bubble;
      // A flushing branch drops the exception of the slot behind it
      misaligned_o        <= ~kill_i & ~flush_o & ctrl_i.misaligned;
      bp_predict_o        <= bp_predict_i;
      bp_btaken_o         <= ctrl_i.taken;
      bp_history_update_o <= bp_history_i;
    end
  end

  ////////////////////
  // Pulses

  // Flush comes out of reset high so fetch starts at PC_INIT
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_o         <= 1'b1;
      ic_invalidate_o <= 1'b0;
      dc_clean_o      <= 1'b0;
      bp_update_o     <= 1'b0;
    end else begin
      flush_o         <= pulse_en & ctrl_i.flush;
      ic_invalidate_o <= pulse_en & ctrl_i.ic_invalidate;
      dc_clean_o      <= pulse_en & ctrl_i.dc_clean;
      bp_update_o     <= pulse_en & ctrl_i.bp_update;
    end
  end

  ////////////////////
  // Global history

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      history <= '0;
    end else if (pulse_en && ctrl_i.bp_update) begin
      history <= {history[BP_GLOBAL_BITS-1:0], ctrl_i.taken};
    end
  end

  // The newest bit is the branch being reported, so leave it out
  assign bp_history_o = history[BP_GLOBAL_BITS:1];

endmodule

//--- branch_unit.sv
// Branch resolution unit
// Resolves jumps, conditional branches and fences at the decode/execute
// boundary and returns a registered next PC, flush and predictor update

`timescale 1ns/1ns

module branch_unit #(
  parameter int              XLEN           = 32,
  parameter logic [XLEN-1:0] PC_INIT        = 'h200,
  parameter int              BP_GLOBAL_BITS = 2,
  parameter int              HAS_RVC        = 0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      stall_i,
  input  logic                      kill_i,
  input  logic                      bubble_i,
  input  branch_pkg::insn_t         insn_i,
  input  logic [XLEN-1:0]           pc_i,
  input  logic [XLEN-1:0]           opa_i,
  input  logic [XLEN-1:0]           opb_i,
  input  branch_pkg::bp_predict_t   bp_predict_i,
  input  logic [BP_GLOBAL_BITS-1:0] bp_history_i,
  input  logic                      misaligned_i,
  output logic [XLEN-1:0]           nxt_pc_o,
  output logic                      bubble_o,
  output logic                      flush_o,
  output logic                      ic_invalidate_o,
  output logic                      dc_clean_o,
  output logic                      misaligned_o,
  output branch_pkg::bp_predict_t   bp_predict_o,
  output logic                      bp_btaken_o,
  output logic                      bp_update_o,
  output logic [BP_GLOBAL_BITS-1:0] bp_history_update_o,
  output logic [BP_GLOBAL_BITS-1:0] bp_history_o
);
  import branch_pkg::*;

  br_decode_t      dec;
  br_ctrl_t        ctrl;
  logic [XLEN-1:0] nxt_pc;

  branch_decode decode_i (
    .insn_i   (insn_i),
    .bubble_i (bubble_i),
    .dec_o    (dec)
  );

  branch_execute #(
    .XLEN    (XLEN),
    .HAS_RVC (HAS_RVC)
  ) execute_i (
    .dec_i        (dec),
    .pc_i         (pc_i),
    .opa_i        (opa_i),
    .opb_i        (opb_i),
    .bp_predict_i (bp_predict_i),
    .misaligned_i (misaligned_i),
    .ctrl_o       (ctrl),
    .nxt_pc_o     (nxt_pc)
  );

  branch_result #(
    .XLEN           (XLEN),
    .PC_INIT        (PC_INIT),
    .BP_GLOBAL_BITS (BP_GLOBAL_BITS)
  ) result_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .stall_i             (stall_i),
    .kill_i              (kill_i),
    .ctrl_i              (ctrl),
    .nxt_pc_i            (nxt_pc),
    .bp_predict_i        (bp_predict_i),
    .bp_history_i        (bp_history_i),
    .nxt_pc_o            (nxt_pc_o),
    .bubble_o            (bubble_o),
    .flush_o             (flush_o),
    .ic_invalidate_o     (ic_invalidate_o),
    .dc_clean_o          (dc_clean_o),
    .misaligned_o        (misaligned_o),
    .bp_predict_o        (bp_predict_o),
    .bp_btaken_o         (bp_btaken_o),
    .bp_update_o         (bp_update_o),
    .bp_history_update_o (bp_history_update_o),
    .bp_history_o        (bp_history_o)
  );

endmodule

//--- branch_unit_assertions.sv
// Branch unit output checks
// Concurrent assertions on the relations between the registered outputs,
// bound into every branch_unit instance

`timescale 1ns/1ns

module branch_unit_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic stall_i,
  input logic bubble_o,
  input logic flush_o,
  input logic ic_invalidate_o,
  input logic bp_update_o,
  input logic misaligned_o
);

  // Number of assertion failures seen so far
  int fail_count = 0;

  // The reset flush arrives together with a bubble, so skip that first cycle
  bubble_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bubble_o && $past(rst_ni)) |-> (!flush_o && !bp_update_o))
    else begin
      fail_count++;
      $error("bubble_o high together with flush_o or bp_update_o");
    end

  icache_flush_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ic_invalidate_o |-> flush_o)
    else begin
      fail_count++;
      $error("ic_invalidate_o high without flush_o");
    end

  // A flushing slot drops the exception of the slot behind it
  flush_drops_exc_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (flush_o && !stall_i) |=> !misaligned_o)
    else begin
      fail_count++;
      $error("misaligned_o high in the cycle after a flush");
    end

endmodule

bind branch_unit branch_unit_assertions assertions_i (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .stall_i         (stall_i),
  .bubble_o        (bubble_o),
  .flush_o         (flush_o),
  .ic_invalidate_o (ic_invalidate_o),
  .bp_update_o     (bp_update_o),
  .misaligned_o    (misaligned_o)
);

//--- tb_branch_unit.sv
// Testbench for the branch resolution unit
// Drives LFSR-generated jumps, branches, fences and plain slots with random
// stall, kill and misaligned inputs, and checks every registered output
// against a reference model with one cycle of latency

`timescale 1ns/1ns

module tb_branch_unit;
  import branch_pkg::*;

  localparam int          XLEN         = 32;
  localparam logic [31:0] PC_INIT      = 32'h200;
  localparam int          GB           = 2;
  localparam int          HAS_RVC      = 0;
  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 5;
  localparam int          NUM_CYCLES   = 3000;
  localparam int          TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 10) * CLK_PERIOD + 100;

  // One slot of stimulus, as applied to the DUT inputs
  typedef struct packed {
    insn_t          insn;
    br_kind_e       kind;
    logic [31:0]    imm;
    logic [31:0]    pc;
    logic [31:0]    opa;
    logic [31:0]    opb;
    logic [1:0]     predict;
    logic [GB-1:0]  history;
    logic           bubble;
    logic           misaligned;
    logic           stall;
    logic           kill;
  } slot_t;

  // Expected outputs plus the model's own history register
  typedef struct packed {
    logic [31:0]   nxt_pc;
    logic          bubble;
    logic          flush;
    logic          ic_invalidate;
    logic          dc_clean;
    logic          misaligned;
    logic [1:0]    bp_predict;
    logic          bp_btaken;
    logic          bp_update;
    logic [GB-1:0] bp_history_update;
    logic [GB:0]   ghist;
  } model_t;

  logic          clk;
  logic          rst_n;
  slot_t         drv;
  model_t        model;
  logic [15:0]   lfsr;
  int            checks;
  int            errors;
  int            n_branch;
  int            n_jump;
  int            n_fence;
  int            n_stall;
  int            n_kill;

  logic [XLEN-1:0] nxt_pc_o;
  logic            bubble_o;
  logic            flush_o;
  logic            ic_invalidate_o;
  logic            dc_clean_o;
  logic            misaligned_o;
  logic [1:0]      bp_predict_o;
  logic            bp_btaken_o;
  logic            bp_update_o;
  logic [GB-1:0]   bp_history_update_o;
  logic [GB-1:0]   bp_history_o;

  branch_unit dut_i (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .stall_i             (drv.stall),
    .kill_i              (drv.kill),
    .bubble_i            (drv.bubble),
    .insn_i              (drv.insn),
    .pc_i                (drv.pc),
    .opa_i               (drv.opa),
    .opb_i               (drv.opb),
    .bp_predict_i        (drv.predict),
    .bp_history_i        (drv.history),
    .misaligned_i        (drv.misaligned),
    .nxt_pc_o            (nxt_pc_o),
    .bubble_o            (bubble_o),
    .flush_o             (flush_o),
    .ic_invalidate_o     (ic_invalidate_o),
    .dc_clean_o          (dc_clean_o),
    .misaligned_o        (misaligned_o),
    .bp_predict_o        (bp_predict_o),
    .bp_btaken_o         (bp_btaken_o),
    .bp_update_o         (bp_update_o),
    .bp_history_update_o (bp_history_update_o),
    .bp_history_o        (bp_history_o)
  );

  ////////////////////
  // Random source

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic slot_t idle_slot();
    slot_t s;
    s      = '0;
    s.insn = 32'h0000_0013;
    s.kind = BR_NONE;
    s.pc   = PC_INIT;
    s.bubble = 1'b1;
    return s;
  endfunction

  task automatic make_slot(output slot_t s);
    logic [2:0]  choice;
    logic [2:0]  f3;
    logic [1:0]  opmode;
    logic [12:0] bimm;
    logic [20:0] jimm;
    s            = idle_slot();
    choice       = 3'(take_bits(3));
    s.bubble     = (take_bits(3) == 32'd0);
    s.stall      = (take_bits(3) == 32'd0);
    s.kill       = (take_bits(4) == 32'd0);
    s.misaligned = (take_bits(4) == 32'd0);
    s.predict    = 2'(take_bits(2));
    s.history    = GB'(take_bits(GB));
    s.pc         = {30'(take_bits(30)), 2'b00};
    opmode       = 2'(take_bits(2));
    s.opb        = take_bits(32);
    // Equal and sign-differing pairs hit the comparison corners
    case (opmode)
      2'd0: s.opa = s.opb;
      2'd1: s.opa = {~s.opb[31], 31'(take_bits(31))};
      default: s.opa = take_bits(32);
    endcase
    case (choice)
      3'd0, 3'd1: begin
        f3 = 3'(take_bits(3));
        case (f3)
          3'b010: f3 = F3_BEQ;
          3'b011: f3 = F3_BNE;
          default: ;
        endcase
        bimm   = {12'(take_bits(12)), 1'b0};
        s.kind = BR_BRANCH;
        s.imm  = {{19{bimm[12]}}, bimm};
        s.insn = {bimm[12], bimm[10:5], 10'(take_bits(10)), f3, bimm[4:1], bimm[11],
                  OPC_BRANCH};
        n_branch++;
      end
      3'd2: begin
        jimm   = {20'(take_bits(20)), 1'b0};
        s.kind = BR_JAL;
        s.imm  = {{11{jimm[20]}}, jimm};
        s.insn = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'(take_bits(5)), OPC_JAL};
        n_jump++;
      end
      3'd3: begin
        s.kind = BR_JALR;
        s.insn = {17'(take_bits(17)), F3_JALR, 5'(take_bits(5)), OPC_JALR};
        n_jump++;
      end
      3'd4: begin
        s.kind = BR_FENCE;
        s.insn = {12'(take_bits(12)), 5'd0, F3_FENCE, 5'd0, OPC_MISCMEM};
        n_fence++;
      end
      3'd5: begin
        s.kind = BR_FENCE_I;
        s.insn = {12'd0, 5'd0, F3_FENCE_I, 5'd0, OPC_MISCMEM};
        n_fence++;
      end
      default: begin
        // Opcode 01100xx is never control flow and the low bits pick 16 or 32 bit
        s.kind = BR_NONE;
        s.insn = {25'(take_bits(25)), 5'b01100, 2'(take_bits(2))};
      end
    endcase
    if (s.stall) begin
      n_stall++;
    end
    if (s.kill) begin
      n_kill++;
    end
  endtask

  ////////////////////
  // Reference model

  function automatic model_t reset_model();
    model_t m;
    m        = '0;
    m.nxt_pc = PC_INIT;
    m.bubble = 1'b1;
    m.flush  = 1'b1;
    return m;
  endfunction

  function automatic model_t ref_step(input model_t m, input slot_t s);
    model_t      n;
    br_kind_e    kind;
    logic [31:0] seq;
    logic [31:0] rel;
    logic [31:0] tgt;
    logic        cond;
    logic        taken;
    logic        flush;
    logic        upd;
    logic        fence_i;
    logic        bub;
    logic        flow;
    logic        bad;
    logic        mis;
    logic        en;
    n       = m;
    kind    = s.bubble ? BR_NONE : s.kind;
    seq     = s.pc + ((s.insn[1:0] != 2'b11) ? 32'd2 : 32'd4);
    rel     = s.pc + s.imm;
    tgt     = seq;
    taken   = 1'b0;
    flush   = 1'b0;
    upd     = 1'b0;
    fence_i = 1'b0;
    bub     = 1'b0;
    flow    = 1'b0;
    case (s.insn[14:12])
      F3_BEQ:  cond = (s.opa == s.opb);
      F3_BNE:  cond = (s.opa != s.opb);
      F3_BLT:  cond = ($signed(s.opa) < $signed(s.opb));
      F3_BGE:  cond = ($signed(s.opa) >= $signed(s.opb));
      F3_BLTU: cond = (s.opa < s.opb);
      F3_BGEU: cond = (s.opa >= s.opb);
      default: cond = 1'b0;
    endcase
    case (kind)
      BR_JAL: begin
        taken = 1'b1;
        flush = ~s.predict[1];
        tgt   = rel;
        flow  = 1'b1;
      end
      BR_JALR: begin
        taken = 1'b1;
        flush = 1'b1;
        tgt   = (s.opa + s.opb) & ~32'd1;
        flow  = 1'b1;
      end
      BR_BRANCH: begin
        taken = cond;
        upd   = 1'b1;
        flush = cond ^ s.predict[1];
        tgt   = cond ? rel : seq;
        flow  = 1'b1;
      end
      BR_FENCE_I: begin
        flush   = 1'b1;
        fence_i = 1'b1;
      end
      BR_FENCE: ;
      default: bub = 1'b1;
    endcase
    // 2-byte alignment checks bit 0 only, 4-byte alignment both low bits
    if (HAS_RVC != 0) begin
      bad = tgt[0];
    end else begin
      bad = tgt[1] | tgt[0];
    end
    mis = s.misaligned | (flow & bad);
    en  = ~s.stall & ~s.kill;
    if (!s.stall) begin
      n.nxt_pc            = tgt;
      n.bubble            = s.kill | bub;
      n.misaligned        = ~s.kill & ~m.flush & mis;
      n.bp_predict        = s.predict;
      n.bp_btaken         = taken;
      n.bp_history_update = s.history;
    end
    n.flush         = en & flush;
    n.ic_invalidate = en & fence_i;
    n.dc_clean      = en & fence_i;
    n.bp_update     = en & upd;
    if (en && upd) begin
      n.ghist = {m.ghist[GB-1:0], taken};
    end
    return n;
  endfunction

  ////////////////////
  // Checking

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic compare_outputs();
    check_value("nxt_pc_o", model.nxt_pc, nxt_pc_o);
    check_value("bubble_o", 32'(model.bubble), 32'(bubble_o));
    check_value("flush_o", 32'(model.flush), 32'(flush_o));
    check_value("ic_invalidate_o", 32'(model.ic_invalidate), 32'(ic_invalidate_o));
    check_value("dc_clean_o", 32'(model.dc_clean), 32'(dc_clean_o));
    check_value("misaligned_o", 32'(model.misaligned), 32'(misaligned_o));
    check_value("bp_predict_o", 32'(model.bp_predict), 32'(bp_predict_o));
    check_value("bp_btaken_o", 32'(model.bp_btaken), 32'(bp_btaken_o));
    check_value("bp_update_o", 32'(model.bp_update), 32'(bp_update_o));
    check_value("bp_history_update_o", 32'(model.bp_history_update),
                32'(bp_history_update_o));
    check_value("bp_history_o", 32'(model.ghist[GB:1]), 32'(bp_history_o));
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Model steps with the slot that was present at the edge
  initial begin
    model = reset_model();
    forever begin
      @(posedge clk);
      if (rst_n) begin
        model = ref_step(model, drv);
      end else begin
        model = reset_model();
      end
      #2;
      compare_outputs();
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////
  // Stimulus

  initial begin
    slot_t s;
    int    sva_fails;
    lfsr     = 16'd11;
    checks   = 0;
    errors   = 0;
    n_branch = 0;
    n_jump   = 0;
    n_fence  = 0;
    n_stall  = 0;
    n_kill   = 0;
    rst_n    = 1'b0;
    drv      = idle_slot();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < NUM_CYCLES; i++) begin
      make_slot(s);
      drv = s;
      @(posedge clk);
      #1;
    end
    drv = idle_slot();
    @(posedge clk);
    #3;
    sva_fails = dut_i.assertions_i.fail_count;
    $display("checks=%0d errors=%0d sva_fails=%0d br=%0d jmp=%0d fence=%0d stall=%0d kill=%0d",
             checks, errors, sva_fails, n_branch, n_jump, n_fence, n_stall, n_kill);
    if (errors == 0 && sva_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
branch_pkg.sv
branch_decode.sv
branch_execute.sv
branch_result.sv
branch_unit.sv
branch_unit_assertions.sv
tb_branch_unit.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the branch unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f vlog.f --top-module tb_branch_unit -o sim_branch_unit

./obj_dir/sim_branch_unit 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"
